// File: edgeConfig.sv
/*
 * Configuration registers: threshold and output mode
 */
`timescale 1ns/10ps

module edgeConfig #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                                       pclk_i,
    input  logic                                       reset_i,
    input  logic                                       cfgWe_i,    // One-cycle strobe
    input  logic                                       cfgAddr_i,
    input  logic [edgePkg::CFG_WIDTH-1:0]              cfgData_i,
    output logic [DATA_WIDTH+edgePkg::GRAD_MARGIN-1:0] threshold_o,
    output logic                                       binarize_o
);

    localparam int GRAD_WIDTH = DATA_WIDTH + edgePkg::GRAD_MARGIN;

    // Write word seen through both register views
    edgePkg::cfgWord_u cfgWord;

    assign cfgWord = cfgData_i;

    always_ff @(posedge pclk_i) begin
        if (reset_i) begin
            threshold_o <= GRAD_WIDTH'(edgePkg::THRESH_RESET);
            binarize_o  <= 1'b0;  // Grey mode
        end else if (cfgWe_i) begin
            if (cfgAddr_i == edgePkg::CFG_ADDR_CTRL) begin
                binarize_o <= cfgWord.ctrl.binarize;  // Reserved bits ignored
            end else begin
                // Threshold register, full gradient width
                threshold_o <= GRAD_WIDTH'(cfgWord.thresh.value);
            end
        end
    end

endmodule

// File: edgePkg.sv
/*
 * Shared widths, configuration addresses, reset values
 * and the configuration write word union
 */
package edgePkg;

    localparam int PIX_WIDTH     = 8;   // Default pixel width
    localparam int GRAD_MARGIN   = 3;   // Extra gradient bits beyond the pixel
    localparam int CFG_WIDTH     = 16;  // Configuration data word
    localparam int THRESH_BITS   = PIX_WIDTH + GRAD_MARGIN;

    // Register addresses, one bit wide
    localparam logic CFG_ADDR_THRESH = 1'b0;
    localparam logic CFG_ADDR_CTRL   = 1'b1;

    localparam int THRESH_RESET  = 255; // Threshold after reset
    localparam int SOBEL_LATENCY = 4;   // Kernel depth in cycles

    // Threshold view, value sits in the low bits
    typedef struct packed {
        logic [CFG_WIDTH-THRESH_BITS-1:0] unused;
        logic [THRESH_BITS-1:0]           value;
    } threshView_t;

    // Control view, binarize in bit 0
    typedef struct packed {
        logic [CFG_WIDTH-2:0] reserved;
        logic                 binarize;
    } ctrlView_t;

    // Same write word, decoded by address
    typedef union packed {
        threshView_t thresh;
        ctrlView_t   ctrl;
    } cfgWord_u;

endpackage

// File: edgeSobel.sv
/*
 * Four-stage Sobel kernel with gradients, absolute values, magnitude sum
 * and threshold, and the sync levels carried alongside
 */
`timescale 1ns/10ps

module edgeSobel #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                                       pclk_i,
    input  logic                                       reset_i,
    input  logic [DATA_WIDTH-1:0]                      winP1_i,
    input  logic [DATA_WIDTH-1:0]                      winP2_i,
    input  logic [DATA_WIDTH-1:0]                      winP3_i,
    input  logic [DATA_WIDTH-1:0]                      winP4_i,
    input  logic [DATA_WIDTH-1:0]                      winP5_i,
    input  logic [DATA_WIDTH-1:0]                      winP6_i,
    input  logic [DATA_WIDTH-1:0]                      winP7_i,
    input  logic [DATA_WIDTH-1:0]                      winP8_i,
    input  logic [DATA_WIDTH-1:0]                      winP9_i,
    input  logic                                       fsync_i,
    input  logic                                       rsync_i,
    input  logic [DATA_WIDTH+edgePkg::GRAD_MARGIN-1:0] threshold_i,
    input  logic                                       binarize_i,
    output logic                                       fsync_o,
    output logic                                       rsync_o,
    output logic [DATA_WIDTH-1:0]                      pdata_o
);

    localparam int GRAD_WIDTH = DATA_WIDTH + edgePkg::GRAD_MARGIN;
    localparam int LAT        = edgePkg::SOBEL_LATENCY;

    logic [GRAD_WIDTH-1:0] gxPos;
    logic [GRAD_WIDTH-1:0] gxNeg;
    logic [GRAD_WIDTH-1:0] gyPos;
    logic [GRAD_WIDTH-1:0] gyNeg;
    logic [GRAD_WIDTH:0]   magSum;     // One spare bit for the carry

    logic signed [GRAD_WIDTH-1:0] gx;  // Stage 1
    logic signed [GRAD_WIDTH-1:0] gy;
    logic [GRAD_WIDTH-1:0]        absGx;  // Stage 2
    logic [GRAD_WIDTH-1:0]        absGy;
    logic [GRAD_WIDTH-1:0]        mag;    // Stage 3

    logic [LAT-1:0] fsPipe;  // Sync levels with one bit per stage
    logic [LAT-1:0] rsPipe;

    // Weighted column and row sums of the zero-extended pixels
    always_comb begin
        gxPos = GRAD_WIDTH'(winP3_i) + (GRAD_WIDTH'(winP6_i) << 1) + GRAD_WIDTH'(winP9_i);
        gxNeg = GRAD_WIDTH'(winP1_i) + (GRAD_WIDTH'(winP4_i) << 1) + GRAD_WIDTH'(winP7_i);
        gyPos = GRAD_WIDTH'(winP7_i) + (GRAD_WIDTH'(winP8_i) << 1) + GRAD_WIDTH'(winP9_i);
        gyNeg = GRAD_WIDTH'(winP1_i) + (GRAD_WIDTH'(winP2_i) << 1) + GRAD_WIDTH'(winP3_i);

        magSum = {1'b0, absGx} + {1'b0, absGy};
    end

    // Data stages
    always_ff @(posedge pclk_i) begin
        // Stage 1 forms the signed gradients
        gx <= $signed(gxPos - gxNeg);
        gy <= $signed(gyPos - gyNeg);

        // Stage 2 takes absolute values
        absGx <= gx[GRAD_WIDTH-1] ? GRAD_WIDTH'(-gx) : GRAD_WIDTH'(gx);
        absGy <= gy[GRAD_WIDTH-1] ? GRAD_WIDTH'(-gy) : GRAD_WIDTH'(gy);

        // Stage 3 sums |Gx| + |Gy| and saturates at the gradient width
        mag <= magSum[GRAD_WIDTH] ? '1 : magSum[GRAD_WIDTH-1:0];
    end

    assign fsync_o = fsPipe[LAT-1];
    assign rsync_o = rsPipe[LAT-1];

    // Stage 4 and the sync pipe
    always_ff @(posedge pclk_i) begin
        if (reset_i) begin
            fsPipe  <= '0;
            rsPipe  <= '0;
            pdata_o <= '0;
        end else begin
            fsPipe <= {fsPipe[LAT-2:0], fsync_i};
            rsPipe <= {rsPipe[LAT-2:0], rsync_i};

            // Only valid pixels update the output
            if (fsPipe[LAT-2] && rsPipe[LAT-2]) begin
                if (mag > threshold_i) begin
                    pdata_o <= '1;                  // Edge pixel saturates
                end else if (binarize_i) begin
                    pdata_o <= '0;
                end else begin
                    pdata_o <= mag[DATA_WIDTH-1:0]; // Grey mode keeps the low magnitude bits
                end
            end
        end
    end

endmodule

// File: edgeTbModel.svh
/*
 * Bordered pixel fetch, gradient magnitude and output rule of the
 * edge reference model, and the stimulus LFSR
 */
`ifndef EDGE_TB_MODEL_SVH
`define EDGE_TB_MODEL_SVH

localparam int TB_FRAME_ROWS = 6;
localparam int TB_FRAME_COLS = 12;

typedef int tbFrame_t [TB_FRAME_ROWS][TB_FRAME_COLS];

// Negative row or column reads as zero
function automatic int pixAt(tbFrame_t f, int r, int c);
    if (r < 0 || c < 0) begin
        return 0;
    end
    return f[r][c];
endfunction

// Saturated |Gx| + |Gy| over rows r-2..r and columns c-2..c
function automatic int sobelMag(tbFrame_t f, int r, int c);
    int gx;
    int gy;
    int mag;
    int sat;
    sat = (1 << (edgePkg::PIX_WIDTH + edgePkg::GRAD_MARGIN)) - 1;
    gx = (pixAt(f, r-2, c) + 2 * pixAt(f, r-1, c) + pixAt(f, r, c))
       - (pixAt(f, r-2, c-2) + 2 * pixAt(f, r-1, c-2) + pixAt(f, r, c-2));
    gy = (pixAt(f, r, c-2) + 2 * pixAt(f, r, c-1) + pixAt(f, r, c))
       - (pixAt(f, r-2, c-2) + 2 * pixAt(f, r-2, c-1) + pixAt(f, r-2, c));
    mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
    return (mag > sat) ? sat : mag;
endfunction

// Threshold rule for grey and binary mode
function automatic int expectPix(int mag, int thresh, bit binarize);
    int ones;
    ones = (1 << edgePkg::PIX_WIDTH) - 1;
    if (mag > thresh) begin
        return ones;
    end
    return binarize ? 0 : (mag & ones);
endfunction

// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 shifting its feedback in at bit 0
function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// File: edgeTb.sv
/*
 * Edge detection testbench with clock, reset, frame stimulus,
 * expected-output queue, output checks and cycle limit
 */
`timescale 1ns/10ps

module edgeTb;

    `include "edgeTbModel.svh"

    localparam int DATA_WIDTH = 8;
    localparam int LINE_WIDTH = 16;

    // Frame sources
    localparam int SRC_RANDOM  = 0;
    localparam int SRC_CONST   = 1;   // Flat 200
    localparam int SRC_COLUMNS = 2;   // 255 on even columns and 0 on odd ones

    // Extra checks carried with each expected pixel
    localparam int KIND_ANY    = 0;
    localparam int KIND_BINARY = 1;   // Only zero or all ones
    localparam int KIND_NOSAT  = 2;   // Never all ones

    localparam int ROW_GAP      = 3;
    localparam int FRAME_GAP    = 8;
    localparam int FRAME_CYCLES = 1 + TB_FRAME_ROWS * TB_FRAME_COLS
                                + (TB_FRAME_ROWS - 1) * ROW_GAP + FRAME_GAP;
    localparam int DRAIN_CYCLES = 2 * edgePkg::SOBEL_LATENCY + 4;
    localparam int STIM_CYCLES  = 16 + 4 + 4 * FRAME_CYCLES + 4 * 2 + DRAIN_CYCLES;
    localparam int CYCLE_LIMIT  = 2 * STIM_CYCLES;

    logic                          pclk_i;
    logic                          reset_i;
    logic                          fsync_i;
    logic                          rsync_i;
    logic [DATA_WIDTH-1:0]         pixel_i;
    logic                          cfgWe_i;
    logic                          cfgAddr_i;
    logic [edgePkg::CFG_WIDTH-1:0] cfgData_i;
    logic                          fsync_o;
    logic                          rsync_o;
    logic [DATA_WIDTH-1:0]         pdata_o;

    tbFrame_t              frame;          // Pixels of the frame being sent
    logic [31:0]           lfsrState;
    int                    tbThresh;       // Configuration as written so far
    bit                    tbBin;
    int                    expQ[$];        // Expected pdata_o per valid pixel
    time                   timeQ[$];       // When that pixel was driven
    int                    kindQ[$];
    logic [4:0]            fsHist = '0;    // Input sync levels with the newest in bit 0
    logic [4:0]            rsHist = '0;
    logic [DATA_WIDTH-1:0] lastPdata = '0;
    int                    cycleCnt = 0;

    edgeTop #(
        .DATA_WIDTH (DATA_WIDTH),
        .LINE_WIDTH (LINE_WIDTH)
    ) i_dut (
        .pclk_i    (pclk_i),
        .reset_i   (reset_i),
        .fsync_i   (fsync_i),
        .rsync_i   (rsync_i),
        .pixel_i   (pixel_i),
        .cfgWe_i   (cfgWe_i),
        .cfgAddr_i (cfgAddr_i),
        .cfgData_i (cfgData_i),
        .fsync_o   (fsync_o),
        .rsync_o   (rsync_o),
        .pdata_o   (pdata_o)
    );

    initial begin
        pclk_i = 1'b0;
        forever #2 pclk_i = ~pclk_i;  // 4 ns period
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic valueFail(input string sig, input int expV, input int actV,
                             input string note);
        abortRun($sformatf("Fail at %0d ns: %s expected %0d, got %0d%s",
                           $time, sig, expV, actV, note));
    endtask

    // One pixel from the LFSR with one step per bit
    function automatic logic [DATA_WIDTH-1:0] randPixel();
        logic [DATA_WIDTH-1:0] v;
        v = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[DATA_WIDTH-2:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic int framePixel(input int src, input int c);
        case (src)
            SRC_CONST:   return 200;
            SRC_COLUMNS: return (c % 2 == 0) ? 255 : 0;
            default:     return int'(randPixel());
        endcase
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic driveInputs(input logic f, input logic r, input int p);
        @(posedge pclk_i);
        #1;
        fsync_i = f;
        rsync_i = r;
        pixel_i = p[DATA_WIDTH-1:0];
    endtask

    task automatic writeCfg(input logic addr, input logic [edgePkg::CFG_WIDTH-1:0] data);
        @(posedge pclk_i);
        #1;
        cfgWe_i   = 1'b1;
        cfgAddr_i = addr;
        cfgData_i = data;
        @(posedge pclk_i);
        #1;
        cfgWe_i = 1'b0;
        if (addr == edgePkg::CFG_ADDR_CTRL) begin
            tbBin = data[0];
        end else begin
            tbThresh = int'(data[edgePkg::THRESH_BITS-1:0]);
        end
    endtask

    task automatic sendFrame(input int src, input int kind);
        int p;
        driveInputs(1'b1, 1'b0, 0);  // Frame opens a cycle ahead of row 0
        for (int r = 0; r < TB_FRAME_ROWS; r++) begin
            for (int c = 0; c < TB_FRAME_COLS; c++) begin
                p = framePixel(src, c);
                frame[r][c] = p;
                driveInputs(1'b1, 1'b1, p);
                expQ.push_back(expectPix(sobelMag(frame, r, c), tbThresh, tbBin));
                timeQ.push_back($time);
                kindQ.push_back(kind);
            end
            if (r < TB_FRAME_ROWS - 1) begin
                repeat (ROW_GAP) driveInputs(1'b1, 1'b0, 0);  // Row blanking
            end
        end
        repeat (FRAME_GAP) driveInputs(1'b0, 1'b0, 0);
    endtask

    initial begin
        reset_i   = 1'b1;
        fsync_i   = 1'b0;
        rsync_i   = 1'b0;
        pixel_i   = '0;
        cfgWe_i   = 1'b0;
        cfgAddr_i = 1'b0;
        cfgData_i = '0;
        lfsrState = 32'h87e0_d80d;
        tbThresh  = edgePkg::THRESH_RESET;
        tbBin     = 1'b0;
        repeat (16) @(posedge pclk_i);
        #1 reset_i = 1'b0;
        repeat (4) driveInputs(1'b0, 1'b0, 0);

        sendFrame(SRC_RANDOM, KIND_ANY);                      // Grey mode at threshold 255
        writeCfg(edgePkg::CFG_ADDR_THRESH, 16'd60);
        writeCfg(edgePkg::CFG_ADDR_CTRL, 16'h8001);           // Reserved bit set too
        sendFrame(SRC_RANDOM, KIND_BINARY);
        sendFrame(SRC_CONST, KIND_BINARY);                    // Borders only
        writeCfg(edgePkg::CFG_ADDR_THRESH, 16'd2047);         // Full 11-bit threshold
        writeCfg(edgePkg::CFG_ADDR_CTRL, 16'h0000);
        sendFrame(SRC_COLUMNS, KIND_NOSAT);                   // Truncation path

        repeat (DRAIN_CYCLES) @(posedge pclk_i);
        @(negedge pclk_i);
        if (expQ.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abortRun($sformatf("%0d expected pixels never came out", expQ.size()));
        end
    end

    always @(posedge pclk_i) begin
        cycleCnt = cycleCnt + 1;
        if (cycleCnt > CYCLE_LIMIT) begin
            abortRun("Timeout: the run went past its cycle limit");
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge pclk_i) begin
        int  expVal;
        int  kindVal;
        time drvTime;
        if (cycleCnt > 0) begin  // Nothing is registered before the first rising edge
            if (reset_i) begin
                assert (!fsync_o)
                    else valueFail("fsync_o", 0, int'(fsync_o), " (reset held)");
                assert (!rsync_o)
                    else valueFail("rsync_o", 0, int'(rsync_o), " (reset held)");
                assert (pdata_o == '0)
                    else valueFail("pdata_o", 0, int'(pdata_o), " (reset held)");
            end
            assert (fsync_o == fsHist[4])
                else valueFail("fsync_o", int'(fsHist[4]), int'(fsync_o), "");
            assert (rsync_o == rsHist[4])
                else valueFail("rsync_o", int'(rsHist[4]), int'(rsync_o), "");

            if (fsync_o && rsync_o) begin
                if (expQ.size() == 0) begin
                    abortRun("Valid output with no pixel outstanding");
                end else begin
                    expVal  = expQ.pop_front();
                    drvTime = timeQ.pop_front();
                    kindVal = kindQ.pop_front();
                    if (kindVal == KIND_BINARY) begin
                        assert (pdata_o == '0 || pdata_o == '1)
                            else valueFail("pdata_o", expVal, int'(pdata_o),
                                           " (binary mode gave neither zero nor all ones)");
                    end
                    if (kindVal == KIND_NOSAT) begin
                        assert (pdata_o != '1)
                            else valueFail("pdata_o", expVal, int'(pdata_o),
                                           " (saturated below the threshold)");
                    end
                    assert (int'(pdata_o) == expVal)
                        else valueFail("pdata_o", expVal, int'(pdata_o),
                                       $sformatf(" (pixel driven at %0d ns)", drvTime));
                end
            end else begin
                assert (pdata_o == lastPdata)  // Holds between valid pixels
                    else valueFail("pdata_o", int'(lastPdata), int'(pdata_o), " (hold)");
            end

            lastPdata = pdata_o;
            fsHist    = {fsHist[3:0], fsync_i};
            rsHist    = {rsHist[3:0], rsync_i};
        end
    end

endmodule

// File: edgeTop.sv
/*
 * Edge detection top: line window, configuration block and Sobel kernel
 */
`timescale 1ns/10ps

module edgeTop #(
    parameter int DATA_WIDTH = edgePkg::PIX_WIDTH,
    parameter int LINE_WIDTH = 16
) (
    input  logic                          pclk_i,
    input  logic                          reset_i,
    input  logic                          fsync_i,
    input  logic                          rsync_i,
    input  logic [DATA_WIDTH-1:0]         pixel_i,
    input  logic                          cfgWe_i,
    input  logic                          cfgAddr_i,
    input  logic [edgePkg::CFG_WIDTH-1:0] cfgData_i,
    output logic                          fsync_o,
    output logic                          rsync_o,
    output logic [DATA_WIDTH-1:0]         pdata_o
);

    localparam int GRAD_WIDTH = DATA_WIDTH + edgePkg::GRAD_MARGIN;

    // Window to kernel
    logic [DATA_WIDTH-1:0] winP1, winP2, winP3;  // Two rows above
    logic [DATA_WIDTH-1:0] winP4, winP5, winP6;  // Row above
    logic [DATA_WIDTH-1:0] winP7, winP8, winP9;  // Current row, P9 newest
    logic                  winFsync;
    logic                  winRsync;

    // Configuration to kernel
    logic [GRAD_WIDTH-1:0] threshold;
    logic                  binarize;

    lineWindow #(
        .DATA_WIDTH (DATA_WIDTH),
        .LINE_WIDTH (LINE_WIDTH)
    ) i_lineWindow (
        .pclk_i     (pclk_i),
        .reset_i    (reset_i),
        .fsync_i    (fsync_i),
        .rsync_i    (rsync_i),
        .pixel_i    (pixel_i),
        .winP1_o    (winP1),
        .winP2_o    (winP2),
        .winP3_o    (winP3),
        .winP4_o    (winP4),
        .winP5_o    (winP5),
        .winP6_o    (winP6),
        .winP7_o    (winP7),
        .winP8_o    (winP8),
        .winP9_o    (winP9),
        .winFsync_o (winFsync),
        .winRsync_o (winRsync)
    );

    edgeConfig #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_edgeConfig (
        .pclk_i      (pclk_i),
        .reset_i     (reset_i),
        .cfgWe_i     (cfgWe_i),
        .cfgAddr_i   (cfgAddr_i),
        .cfgData_i   (cfgData_i),
        .threshold_o (threshold),
        .binarize_o  (binarize)
    );

    edgeSobel #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_edgeSobel (
        .pclk_i      (pclk_i),
        .reset_i     (reset_i),
        .winP1_i     (winP1),
        .winP2_i     (winP2),
        .winP3_i     (winP3),
        .winP4_i     (winP4),
        .winP5_i     (winP5),
        .winP6_i     (winP6),
        .winP7_i     (winP7),
        .winP8_i     (winP8),
        .winP9_i     (winP9),
        .fsync_i     (winFsync),
        .rsync_i     (winRsync),
        .threshold_i (threshold),
        .binarize_i  (binarize),
        .fsync_o     (fsync_o),
        .rsync_o     (rsync_o),
        .pdata_o     (pdata_o)
    );

endmodule

// File: files.f
+incdir+.
edgePkg.sv
lineWindow.sv
edgeConfig.sv
edgeSobel.sv
edgeTop.sv
edgeTb.sv

// File: lineWindow.sv
/*
 * Line window: two row buffers, row/column counters,
 * border masking and the registered 3x3 window
 */
`timescale 1ns/10ps

module lineWindow #(
    parameter int DATA_WIDTH = 8,
    parameter int LINE_WIDTH = 16
) (
    input  logic                  pclk_i,
    input  logic                  reset_i,
    input  logic                  fsync_i,
    input  logic                  rsync_i,
    input  logic [DATA_WIDTH-1:0] pixel_i,
    output logic [DATA_WIDTH-1:0] winP1_o,
    output logic [DATA_WIDTH-1:0] winP2_o,
    output logic [DATA_WIDTH-1:0] winP3_o,
    output logic [DATA_WIDTH-1:0] winP4_o,
    output logic [DATA_WIDTH-1:0] winP5_o,
    output logic [DATA_WIDTH-1:0] winP6_o,
    output logic [DATA_WIDTH-1:0] winP7_o,
    output logic [DATA_WIDTH-1:0] winP8_o,
    output logic [DATA_WIDTH-1:0] winP9_o,
    output logic                  winFsync_o,
    output logic                  winRsync_o
);

    localparam int COL_WIDTH = (LINE_WIDTH > 1) ? $clog2(LINE_WIDTH) : 1;

    logic [DATA_WIDTH-1:0] lineMemA [LINE_WIDTH];  // Row r-1
    logic [DATA_WIDTH-1:0] lineMemB [LINE_WIDTH];  // Row r-2

    logic                 fsyncQ;
    logic                 rsyncQ;
    logic                 fsyncRise;
    logic                 rsyncRise;
    logic                 pixValid;
    logic [COL_WIDTH-1:0] colCnt;   // Column of the next pixel
    logic [COL_WIDTH-1:0] colIdx;   // Column of the current pixel
    logic [1:0]           rowCnt;   // Rows started this frame, saturates at 3
    logic [1:0]           rowIdx;   // Row of the current pixel, 3 means deep enough
    logic                 maskTop1;
    logic                 maskTop2;
    logic                 maskLeft1;
    logic                 maskLeft2;
    logic [DATA_WIDTH-1:0] upPix;
    logic [DATA_WIDTH-1:0] upUpPix;

    always_comb begin
        fsyncRise = fsync_i & ~fsyncQ;
        rsyncRise = rsync_i & ~rsyncQ;
        pixValid  = fsync_i & rsync_i;

        colIdx = rsyncRise ? '0 : colCnt;  // Row start restarts the column

        if (fsyncRise) begin
            rowIdx = 2'd0;                 // First row of a new frame
        end else if (rsyncRise) begin
            rowIdx = rowCnt;               // New row, not yet counted
        end else begin
            rowIdx = rowCnt - 2'd1;
        end

        // Border rule, negative rows and columns read as zero
        maskTop1  = (rowIdx == 2'd0);
        maskTop2  = (rowIdx < 2'd2);
        maskLeft1 = (colIdx == '0);
        maskLeft2 = (colIdx < COL_WIDTH'(2));

        upPix   = maskTop1 ? '0 : lineMemA[colIdx];  // Same column, row above
        upUpPix = maskTop2 ? '0 : lineMemB[colIdx];  // Same column, two rows above
    end

    // Counters and sync levels
    always_ff @(posedge pclk_i) begin
        if (reset_i) begin
            fsyncQ     <= 1'b0;
            rsyncQ     <= 1'b0;
            colCnt     <= '0;
            rowCnt     <= 2'd0;
            winFsync_o <= 1'b0;
            winRsync_o <= 1'b0;
        end else begin
            fsyncQ     <= fsync_i;
            rsyncQ     <= rsync_i;
            winFsync_o <= fsync_i;   // One cycle, same as the window
            winRsync_o <= rsync_i;

            if (pixValid) begin
                colCnt <= colIdx + 1'b1;
            end else if (rsyncRise) begin
                colCnt <= '0;
            end

            if (fsyncRise) begin
                rowCnt <= {1'b0, rsync_i};  // Row already open counts as started
            end else if (rsyncRise && rowCnt != 2'd3) begin
                rowCnt <= rowCnt + 2'd1;
            end
        end
    end

    // Row buffers and the three-column shift per row
    always_ff @(posedge pclk_i) begin
        if (pixValid) begin
            lineMemA[colIdx] <= pixel_i;
            lineMemB[colIdx] <= lineMemA[colIdx];  // Row r-1 moves down to r-2

            // Current row
            winP9_o <= pixel_i;                        // Newest pixel
            winP8_o <= maskLeft1 ? '0 : winP9_o;
            winP7_o <= maskLeft2 ? '0 : winP8_o;

            // Row above
            winP6_o <= upPix;
            winP5_o <= maskLeft1 ? '0 : winP6_o;
            winP4_o <= maskLeft2 ? '0 : winP5_o;

            // Two rows above
            winP3_o <= upUpPix;
            winP2_o <= maskLeft1 ? '0 : winP3_o;
            winP1_o <= maskLeft2 ? '0 : winP2_o;
        end
    end

endmodule

// File: runSim.sh
#!/bin/sh
# Build the edge detection testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
EXE=edgeTbSim

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module edgeTb \
    -f files.f \
    -o "$EXE" > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status, see $BUILD_LOG"
    exit 1
fi

./obj_dir/"$EXE" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status, see $SIM_LOG"
    exit 1
fi

# The log decides the result
if grep -q "ALL CHECKS PASSED" "$SIM_LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass message missing from $SIM_LOG"
    exit 1
fi
